// ==== Makefile ====
TOP = tb_lc4

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search sim.log for the pass message"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	rm -f sim.log
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== sim/tb_clock_gen.sv ====
module tb_clock_gen #(
   parameter int reset_cycles = 3
) (
   output logic gwe,
   output logic o_reset
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      gwe = 1'b0;
      forever #4 gwe = ~gwe;   // 8 ns period
   end

   initial begin
      o_reset = 1'b1;
      repeat (reset_cycles) @(posedge gwe);
      o_reset <= 1'b0;
   end

endmodule

// ==== sim/tb_lc4.sv ====
module tb_lc4 import lc4_isa_pkg::*, lc4_pipe_pkg::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   localparam word_t base_pc    = 16'h8200;
   localparam int    prog_len   = 640;
   localparam int    n_check    = 600;   // retired instructions before the run ends
   localparam int    idle_limit = 40;

   logic     gwe, i_reset;
   word_t    o_pc, i_insn_a, i_insn_b;
   stall_e   o_stall_a, o_stall_b;
   word_t    o_trace_pc_a, o_trace_pc_b, o_trace_insn_a, o_trace_insn_b;
   logic     o_regfile_we_a, o_regfile_we_b;
   reg_idx_t o_regfile_wsel_a, o_regfile_wsel_b;
   word_t    o_regfile_data_a, o_regfile_data_b;
   logic     o_nzp_we_a, o_nzp_we_b;
   nzp_t     o_nzp_bits_a, o_nzp_bits_b;

   word_t imem [65536];
   word_t m_regs [8];   // ISA model state
   word_t m_pc;

   tb_clock_gen #(.reset_cycles(3)) clock_i (.gwe, .o_reset(i_reset));

   lc4_superscalar #(.reset_pc(base_pc)) dut_i (
      .gwe, .i_reset, .o_pc, .i_insn_a, .i_insn_b,
      .o_stall_a, .o_stall_b, .o_trace_pc_a, .o_trace_pc_b,
      .o_trace_insn_a, .o_trace_insn_b, .o_regfile_we_a, .o_regfile_we_b,
      .o_regfile_wsel_a, .o_regfile_wsel_b, .o_regfile_data_a, .o_regfile_data_b,
      .o_nzp_we_a, .o_nzp_we_b, .o_nzp_bits_a, .o_nzp_bits_b
   );

   bind lc4_issue tb_lc4_chk #(.reset_pc(reset_pc)) chk_i (
      .gwe, .i_reset, .i_pc(o_pc), .i_lane_go(lane_go)
   );

   // instruction memory answers the pair at o_pc
   always_comb begin
      if ($isunknown(o_pc)) begin
         i_insn_a = '0;
         i_insn_b = '0;
      end else begin
         i_insn_a = imem[o_pc];
         i_insn_b = imem[word_t'(o_pc + 16'd1)];
      end
   end

   // branch opcode everywhere outside the program, a no-op here
   function automatic word_t fill_word(word_t a);
      return {4'h0, a[11:0] ^ {a[15:12], a[15:12], a[15:12]}};
   endfunction

   function automatic word_t random_insn(reg_idx_t last_rd, reg_idx_t older_rd);
      reg_idx_t   rd, rs, rt;
      logic [1:0] sub;
      logic [3:0] op;
      word_t      insn;
      rd  = 3'($urandom);
      rs  = 3'($urandom);
      rt  = 3'($urandom);
      sub = 2'($urandom);   // 3 is div on arith
      op  = 4'($urandom);
      case ($urandom_range(0, 7))
         0, 1: rs = last_rd;    // b reads a when the two pair up
         2:    rt = last_rd;
         3:    rs = older_rd;   // dependence into the next pair
         4:    rd = last_rd;    // same register written twice
         default: ;
      endcase
      case ($urandom_range(0, 11))
         0, 1, 2: insn = {4'b0001, rd, rs, 1'b0, sub, rt};
         3:       insn = {4'b0001, rd, rs, 1'b1, 5'($urandom)};
         4, 5:    insn = {4'b0101, rd, rs, 1'b0, sub, rt};
         6:       insn = {4'b0101, rd, rs, 1'b1, 5'($urandom)};
         7, 8:    insn = {4'b1001, rd, 9'($urandom)};
         9:       insn = {4'b1101, rd, 1'b1, 8'($urandom)};
         default: begin
            if (op[1:0] == 2'b01) op[1] = 1'b1;   // kept opcodes all end in 01
            insn = {op, 12'($urandom)};
         end
      endcase
      return insn;
   endfunction

   task automatic load_program();
      word_t a;
      for (int i = 0; i < 65536; i++) begin
         imem[i] = fill_word(word_t'(i));
      end
      for (int i = 0; i < prog_len; i++) begin
         a = base_pc + word_t'(i);
         imem[a] = random_insn(imem[a - 16'd1][11:9], imem[a - 16'd2][11:9]);
      end
   endtask

   // sequential LC4 semantics for the kept subset
   task automatic model_exec(input word_t insn, output logic we, output word_t data);
      word_t rs, rt, imm5, imm9;
      rs   = m_regs[insn[8:6]];
      rt   = m_regs[insn[2:0]];
      imm5 = {{11{insn[4]}}, insn[4:0]};
      imm9 = {{7{insn[8]}}, insn[8:0]};
      we   = 1'b1;
      data = '0;
      case (insn[15:12])
         4'b0001: begin
            if (insn[5]) data = rs + imm5;
            else if (insn[4:3] == 2'd0) data = rs + rt;
            else if (insn[4:3] == 2'd1) data = rs * rt;
            else if (insn[4:3] == 2'd2) data = rs - rt;
            else we = 1'b0;   // div
         end
         4'b0101: begin
            if (insn[5]) data = rs & imm5;
            else if (insn[4:3] == 2'd0) data = rs & rt;
            else if (insn[4:3] == 2'd1) data = ~rs;
            else if (insn[4:3] == 2'd2) data = rs | rt;
            else data = rs ^ rt;
         end
         4'b1001: data = imm9;
         4'b1101: data = {insn[7:0], m_regs[insn[11:9]][7:0]};
         default: we = 1'b0;
      endcase
   endtask

   function automatic logic [2:0] expect_nzp(word_t v);
      if (v == 16'd0) return 3'b010;
      if (v[15]) return 3'b100;
      return 3'b001;
   endfunction

   task automatic abort_run();
      $display("Finished with errors");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_reset_state();
      check("o_pc", o_pc, base_pc);
      check("o_stall_a", 16'(o_stall_a), 16'd1);
      check("o_stall_b", 16'(o_stall_b), 16'd1);
      check("o_regfile_we_a", 16'(o_regfile_we_a), 16'd0);
      check("o_regfile_we_b", 16'(o_regfile_we_b), 16'd0);
      check("o_nzp_we_a", 16'(o_nzp_we_a), 16'd0);
      check("o_nzp_we_b", 16'(o_nzp_we_b), 16'd0);
   endtask

   // compares one retired slot with the next instruction of the model
   task automatic check_slot(input string lane, input word_t pc, input word_t insn,
                             input logic we, input reg_idx_t wsel, input word_t data,
                             input logic nzp_we, input nzp_t nzp);
      logic  exp_we;
      word_t exp_data;
      word_t exp_insn;
      exp_insn = imem[m_pc];
      model_exec(exp_insn, exp_we, exp_data);
      check({"o_trace_pc_", lane}, pc, m_pc);
      check({"o_trace_insn_", lane}, insn, exp_insn);
      check({"o_regfile_we_", lane}, 16'(we), 16'(exp_we));
      check({"o_nzp_we_", lane}, 16'(nzp_we), 16'(exp_we));
      if (exp_we) begin
         check({"o_regfile_wsel_", lane}, 16'(wsel), 16'(exp_insn[11:9]));
         check({"o_regfile_data_", lane}, data, exp_data);
         check({"o_nzp_bits_", lane}, 16'(nzp), 16'(expect_nzp(exp_data)));
         m_regs[exp_insn[11:9]] = exp_data;
      end
      m_pc = m_pc + 16'd1;
   endtask

   initial begin
      int unsigned wait_cycles;
      int unsigned idle;
      int unsigned slots;
      int unsigned retired;
      int unsigned single_cycles;
      int unsigned dual_cycles;
      void'($urandom(32'h8b30_0912));
      load_program();
      for (int r = 0; r < 8; r++) begin
         m_regs[r] = '0;
      end
      m_pc = base_pc;

      wait_cycles = 0;
      do begin
         @(negedge gwe);
         check_reset_state();   // also the first cycle after release
         wait_cycles++;
         if (wait_cycles > 10) begin
            $display("reset was not released within 10 cycles");
            abort_run();
         end
      end while (i_reset);

      idle = 0;
      retired = 0;
      single_cycles = 0;
      dual_cycles = 0;
      while (retired < n_check) begin
         @(negedge gwe);
         slots = 0;
         if (o_stall_a == stall_none) begin
            check_slot("a", o_trace_pc_a, o_trace_insn_a, o_regfile_we_a, o_regfile_wsel_a,
                       o_regfile_data_a, o_nzp_we_a, o_nzp_bits_a);
            slots++;
         end else begin
            check("o_stall_a", 16'(o_stall_a), 16'd1);
         end
         if (o_stall_b == stall_none) begin   // lane b is younger within a cycle
            check_slot("b", o_trace_pc_b, o_trace_insn_b, o_regfile_we_b, o_regfile_wsel_b,
                       o_regfile_data_b, o_nzp_we_b, o_nzp_bits_b);
            slots++;
         end else begin
            check("o_stall_b", 16'(o_stall_b), 16'd1);
         end
         if (slots == 0) idle++;
         else idle = 0;
         if (slots == 1) single_cycles++;
         if (slots == 2) dual_cycles++;
         retired += slots;
         if (idle > idle_limit) begin
            $display("timeout, nothing retired for %0d cycles", idle_limit);
            abort_run();
         end
      end

      if (single_cycles == 0 || dual_cycles == 0) begin
         $display("the program never split a pair or never retired a full pair");
         abort_run();
      end else begin
         $display("Finished with no errors");
         $finish;
      end
   end

endmodule

// ==== sim/tb_lc4_chk.sv ====
module tb_lc4_chk import lc4_pipe_pkg::*; #(
   parameter word_t reset_pc = 16'h8200
) (
   input logic               gwe,
   input logic               i_reset,
   input word_t              i_pc,
   input logic [n_lanes-1:0] i_lane_go   // per lane issue this cycle
);
   timeunit 1ns;
   timeprecision 100ps;

   // the pc moves by the number of lanes issued, at most one pair per cycle
   pc_step_a: assert property (@(posedge gwe) disable iff (i_reset)
      !$past(i_reset) |-> ((word_t'(i_pc - $past(i_pc)) inside {16'd0, 16'd1, 16'd2}) &&
                           (word_t'(i_pc - $past(i_pc)) == word_t'($countones($past(i_lane_go))))))
      else $error("pc step does not match the issued lanes");

   b_needs_a_a: assert property (@(posedge gwe) disable iff (i_reset)
      i_lane_go[1] |-> i_lane_go[0])
      else $error("lane b issued without lane a");

   // a held pc means the previous cycle issued nothing
   stall_empty_a: assert property (@(posedge gwe) disable iff (i_reset)
      (!$past(i_reset) && i_pc == $past(i_pc)) |-> ($past(i_lane_go) == '0))
      else $error("pc held although a lane issued");

   reset_pc_a: assert property (@(posedge gwe)
      i_reset |=> (i_pc == reset_pc))
      else $error("pc is not the reset value after reset");

endmodule

// ==== src/lc4_isa_pkg.sv ====
package lc4_isa_pkg;

   // major opcode in insn[15:12]
   // any other code is outside the kept subset and runs as a no-op
   typedef enum logic [3:0] {
      opc_arith   = 4'b0001,
      opc_logic   = 4'b0101,
      opc_const   = 4'b1001,
      opc_hiconst = 4'b1101
   } opcode_e;

   // sub-opcode in insn[5:3] of arith and logic, register form
   // insn[5] set selects the imm5 form instead
   localparam logic [2:0] sub_add = 3'b000;
   localparam logic [2:0] sub_mul = 3'b001;
   localparam logic [2:0] sub_sub = 3'b010;
   localparam logic [2:0] sub_and = 3'b000;
   localparam logic [2:0] sub_not = 3'b001;
   localparam logic [2:0] sub_or  = 3'b010;
   localparam logic [2:0] sub_xor = 3'b011;

   typedef enum logic [3:0] {
      op_nop     = 4'd0,    // writes nothing
      op_add     = 4'd1,
      op_sub     = 4'd2,
      op_mul     = 4'd3,
      op_addi    = 4'd4,
      op_and     = 4'd5,
      op_not     = 4'd6,
      op_or      = 4'd7,
      op_xor     = 4'd8,
      op_andi    = 4'd9,
      op_const   = 4'd10,
      op_hiconst = 4'd11
   } alu_op_e;

   typedef struct packed {
      alu_op_e    alu_op;
      logic [2:0] rd;
      logic       writes_rd;   // also the nzp write enable
      logic       rs_re;
      logic [2:0] rs;
      logic       rt_re;
      logic [2:0] rt;
   } dec_ctrl_t;

   typedef struct packed {
      logic n;
      logic z;
      logic p;
   } nzp_t;

   localparam nzp_t nzp_neg  = 3'b100;
   localparam nzp_t nzp_zero = 3'b010;
   localparam nzp_t nzp_pos  = 3'b001;

endpackage

// ==== src/lc4_issue.sv ====
module lc4_issue import lc4_isa_pkg::*, lc4_pipe_pkg::*; #(
   parameter word_t reset_pc = 16'h8200
) (
   input  logic       gwe,
   input  logic       i_reset,
   input  word_t      i_insn_a,
   input  word_t      i_insn_b,
   output word_t      o_pc,
   output reg_idx_t   o_rs_sel [n_lanes],
   output reg_idx_t   o_rt_sel [n_lanes],
   input  word_t      i_rs_data [n_lanes],
   input  word_t      i_rt_data [n_lanes],
   input  reg_write_t i_retire_wr [n_lanes],
   issue_if.issuer    o_issue [n_lanes]
);

   word_t            pc;
   word_t            insn [n_lanes];
   dec_ctrl_t        ctrl [n_lanes];
   logic [2:0]       sb_count [8];   // in-flight writes per register
   logic [2:0]       sb_inc [8];
   logic [2:0]       sb_dec [8];
   logic [7:0]       pending;
   logic [7:0]       a_wr_mask;
   logic             hazard_a, hazard_b;
   logic [n_lanes-1:0] lane_go;
   logic [1:0]       pc_step;

   function automatic dec_ctrl_t decode(word_t i);
      dec_ctrl_t c;
      c.alu_op = op_nop;
      case (opcode_e'(i[15:12]))
         opc_arith: begin
            if (i[5]) c.alu_op = op_addi;
            else if (i[5:3] == sub_add) c.alu_op = op_add;
            else if (i[5:3] == sub_mul) c.alu_op = op_mul;
            else if (i[5:3] == sub_sub) c.alu_op = op_sub;   // div stays a no-op
         end
         opc_logic: begin
            if (i[5]) c.alu_op = op_andi;
            else if (i[5:3] == sub_and) c.alu_op = op_and;
            else if (i[5:3] == sub_not) c.alu_op = op_not;
            else if (i[5:3] == sub_or) c.alu_op = op_or;
            else if (i[5:3] == sub_xor) c.alu_op = op_xor;
         end
         opc_const:   c.alu_op = op_const;
         opc_hiconst: c.alu_op = op_hiconst;
         default:     c.alu_op = op_nop;
      endcase
      c.writes_rd = c.alu_op != op_nop;
      c.rd = i[11:9];
      c.rs_re = c.writes_rd && c.alu_op != op_const;
      c.rs = (c.alu_op == op_hiconst) ? i[11:9] : i[8:6];   // hiconst reads its own rd
      c.rt_re = c.alu_op inside {op_add, op_sub, op_mul, op_and, op_or, op_xor};
      c.rt = i[2:0];
      return c;
   endfunction

   // true when a source of c is marked in mask
   function automatic logic src_busy(dec_ctrl_t c, logic [7:0] mask);
      return (c.rs_re && mask[c.rs]) || (c.rt_re && mask[c.rt]);
   endfunction

   assign insn[0] = i_insn_a;
   assign insn[1] = i_insn_b;

   for (genvar l = 0; l < n_lanes; l++) begin : g_lane
      assign ctrl[l] = decode(insn[l]);
      assign o_rs_sel[l] = ctrl[l].rs;
      assign o_rt_sel[l] = ctrl[l].rt;
      assign o_issue[l].valid   = lane_go[l];
      assign o_issue[l].pc      = pc + word_t'(l);
      assign o_issue[l].insn    = insn[l];
      assign o_issue[l].ctrl    = ctrl[l];
      assign o_issue[l].rs_data = i_rs_data[l];   // write-through covers this cycle's retire
      assign o_issue[l].rt_data = i_rt_data[l];
   end

   // writes retiring now are already visible through the regfile
   always_comb begin
      for (int r = 0; r < 8; r++) begin
         sb_dec[r] = 3'd0;
         for (int l = 0; l < n_lanes; l++) begin
            if (i_retire_wr[l].we && i_retire_wr[l].wsel == reg_idx_t'(r))
               sb_dec[r] = sb_dec[r] + 3'd1;
         end
         pending[r] = sb_count[r] != sb_dec[r];
      end
   end

   assign a_wr_mask = ctrl[0].writes_rd ? (8'd1 << ctrl[0].rd) : 8'd0;
   assign hazard_a  = src_busy(ctrl[0], pending);
   assign hazard_b  = src_busy(ctrl[1], pending | a_wr_mask);   // split the pair

   assign lane_go[0] = !hazard_a;
   assign lane_go[1] = lane_go[0] && !hazard_b;
   assign pc_step    = 2'(lane_go[0]) + 2'(lane_go[1]);

   always_comb begin
      for (int r = 0; r < 8; r++) begin
         sb_inc[r] = 3'd0;
         for (int l = 0; l < n_lanes; l++) begin
            if (lane_go[l] && ctrl[l].writes_rd && ctrl[l].rd == reg_idx_t'(r))
               sb_inc[r] = sb_inc[r] + 3'd1;
         end
      end
   end

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         pc <= reset_pc;
         for (int r = 0; r < 8; r++) sb_count[r] <= 3'd0;
      end else begin
         pc <= pc + word_t'(pc_step);   // old b becomes new a on a split
         for (int r = 0; r < 8; r++) sb_count[r] <= sb_count[r] + sb_inc[r] - sb_dec[r];
      end
   end

   assign o_pc = pc;

endmodule

// ==== src/lc4_lane.sv ====
module lc4_lane import lc4_isa_pkg::*, lc4_pipe_pkg::*; (
   input  logic   gwe,
   input  logic   i_reset,
   issue_if.lane  i_issue,
   result_if.lane o_result
);

   // execute stage
   logic      ex_valid;
   word_t     ex_pc, ex_insn;
   dec_ctrl_t ex_ctrl;
   word_t     ex_rs, ex_rt;
   word_t     imm5, imm9;
   word_t     alu_out;
   nzp_t      nzp;

   // writeback stage
   logic      wb_valid;
   word_t     wb_pc, wb_insn, wb_data;
   logic      wb_we;
   reg_idx_t  wb_wsel;
   nzp_t      wb_nzp;

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         ex_valid <= 1'b0;
         wb_valid <= 1'b0;
      end else begin
         ex_valid <= i_issue.valid;   // low valid carries a bubble
         wb_valid <= ex_valid;
      end
   end

   always_ff @(posedge gwe) begin
      ex_pc   <= i_issue.pc;
      ex_insn <= i_issue.insn;
      ex_ctrl <= i_issue.ctrl;
      ex_rs   <= i_issue.rs_data;
      ex_rt   <= i_issue.rt_data;
      wb_pc   <= ex_pc;
      wb_insn <= ex_insn;
      wb_we   <= ex_ctrl.writes_rd;
      wb_wsel <= ex_ctrl.rd;
      wb_data <= alu_out;
      wb_nzp  <= nzp;
   end

   assign imm5 = {{11{ex_insn[4]}}, ex_insn[4:0]};
   assign imm9 = {{7{ex_insn[8]}}, ex_insn[8:0]};

   always_comb begin
      case (ex_ctrl.alu_op)
         op_add:     alu_out = ex_rs + ex_rt;
         op_sub:     alu_out = ex_rs - ex_rt;
         op_mul:     alu_out = ex_rs * ex_rt;   // low 16 bits of the product
         op_addi:    alu_out = ex_rs + imm5;
         op_and:     alu_out = ex_rs & ex_rt;
         op_not:     alu_out = ~ex_rs;
         op_or:      alu_out = ex_rs | ex_rt;
         op_xor:     alu_out = ex_rs ^ ex_rt;
         op_andi:    alu_out = ex_rs & imm5;
         op_const:   alu_out = imm9;
         op_hiconst: alu_out = {ex_insn[7:0], ex_rs[7:0]};   // rs holds the old rd
         default:    alu_out = '0;
      endcase
   end

   // nzp from the value written to rd
   assign nzp = (alu_out == '0) ? nzp_zero : (alu_out[15] ? nzp_neg : nzp_pos);

   assign o_result.valid  = wb_valid;
   assign o_result.pc     = wb_pc;
   assign o_result.insn   = wb_insn;
   assign o_result.wr     = '{we: wb_we, wsel: wb_wsel, data: wb_data};
   assign o_result.nzp_we = wb_we;
   assign o_result.nzp    = wb_nzp;

endmodule

// ==== src/lc4_pipe_if.sv ====
// issue packet, captured by the lane on every edge
interface issue_if import lc4_isa_pkg::*, lc4_pipe_pkg::*; ();
   logic      valid;
   word_t     pc;
   word_t     insn;
   dec_ctrl_t ctrl;
   word_t     rs_data;
   word_t     rt_data;

   modport issuer (output valid, pc, insn, ctrl, rs_data, rt_data);
   modport lane   (input  valid, pc, insn, ctrl, rs_data, rt_data);
endinterface

// writeback stage of a lane toward retire
interface result_if import lc4_isa_pkg::*, lc4_pipe_pkg::*; ();
   logic       valid;
   word_t      pc;
   word_t      insn;
   reg_write_t wr;
   logic       nzp_we;
   nzp_t       nzp;

   modport lane   (output valid, pc, insn, wr, nzp_we, nzp);
   modport retire (input  valid, pc, insn, wr, nzp_we, nzp);
endinterface

// ==== src/lc4_pipe_pkg.sv ====
package lc4_pipe_pkg;

   typedef logic [15:0] word_t;
   typedef logic [2:0]  reg_idx_t;

   // trace stall code, 0 marks a retired instruction
   typedef enum logic [1:0] {
      stall_none   = 2'd0,
      stall_bubble = 2'd1
   } stall_e;

   // one register file write, as retired by a lane
   typedef struct packed {
      logic     we;
      reg_idx_t wsel;
      word_t    data;
   } reg_write_t;

   localparam int n_lanes = 2;   // lane a is index 0, lane b index 1

endpackage

// ==== src/lc4_regfile.sv ====
module lc4_regfile import lc4_pipe_pkg::*; (
   input  logic       gwe,
   input  logic       i_reset,
   input  reg_idx_t   i_rs_sel [n_lanes],
   input  reg_idx_t   i_rt_sel [n_lanes],
   output word_t      o_rs_data [n_lanes],
   output word_t      o_rt_data [n_lanes],
   input  reg_write_t i_wr [n_lanes]
);

   word_t    regs [8];
   reg_idx_t rd_sel [2*n_lanes];   // rs ports first, then rt ports
   word_t    rd_data [2*n_lanes];

   for (genvar l = 0; l < n_lanes; l++) begin : g_port
      assign rd_sel[l]           = i_rs_sel[l];
      assign rd_sel[n_lanes + l] = i_rt_sel[l];
      assign o_rs_data[l]        = rd_data[l];
      assign o_rt_data[l]        = rd_data[n_lanes + l];
   end

   // write-through, the higher lane is checked last so lane b wins
   always_comb begin
      for (int p = 0; p < 2*n_lanes; p++) begin
         rd_data[p] = regs[rd_sel[p]];
         for (int l = 0; l < n_lanes; l++) begin
            if (i_wr[l].we && i_wr[l].wsel == rd_sel[p]) rd_data[p] = i_wr[l].data;
         end
      end
   end

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         for (int r = 0; r < 8; r++) regs[r] <= '0;
      end else begin
         for (int l = 0; l < n_lanes; l++) begin
            if (i_wr[l].we) regs[i_wr[l].wsel] <= i_wr[l].data;   // later lane overrides
         end
      end
   end

endmodule

// ==== src/lc4_retire.sv ====
module lc4_retire import lc4_isa_pkg::*, lc4_pipe_pkg::*; (
   input  logic       gwe,
   input  logic       i_reset,
   result_if.retire   i_result [n_lanes],
   output reg_write_t o_wr [n_lanes],
   output stall_e     o_stall [n_lanes],
   output word_t      o_pc [n_lanes],
   output word_t      o_insn [n_lanes],
   output logic       o_regfile_we [n_lanes],
   output reg_idx_t   o_regfile_wsel [n_lanes],
   output word_t      o_regfile_data [n_lanes],
   output logic       o_nzp_we [n_lanes],
   output nzp_t       o_nzp_bits [n_lanes]
);

   for (genvar l = 0; l < n_lanes; l++) begin : g_slot
      logic     slot_we, slot_nzp_we;
      stall_e   stall_q;
      logic     we_q, nzp_we_q;
      word_t    pc_q, insn_q, data_q;
      reg_idx_t wsel_q;
      nzp_t     nzp_q;

      // an empty slot never writes
      assign slot_we     = i_result[l].valid && i_result[l].wr.we;
      assign slot_nzp_we = i_result[l].valid && i_result[l].nzp_we;
      assign o_wr[l] = '{we: slot_we, wsel: i_result[l].wr.wsel, data: i_result[l].wr.data};

      always_ff @(posedge gwe) begin
         if (i_reset) begin
            stall_q  <= stall_bubble;
            we_q     <= 1'b0;
            nzp_we_q <= 1'b0;
         end else begin
            stall_q  <= i_result[l].valid ? stall_none : stall_bubble;
            we_q     <= slot_we;
            nzp_we_q <= slot_nzp_we;
         end
      end

      always_ff @(posedge gwe) begin
         pc_q   <= i_result[l].pc;
         insn_q <= i_result[l].insn;
         wsel_q <= i_result[l].wr.wsel;
         data_q <= i_result[l].wr.data;
         nzp_q  <= i_result[l].nzp;
      end

      assign o_stall[l]        = stall_q;
      assign o_pc[l]           = pc_q;
      assign o_insn[l]         = insn_q;
      assign o_regfile_we[l]   = we_q;
      assign o_regfile_wsel[l] = wsel_q;
      assign o_regfile_data[l] = data_q;
      assign o_nzp_we[l]       = nzp_we_q;
      assign o_nzp_bits[l]     = nzp_q;
   end

endmodule

// ==== src/lc4_superscalar.sv ====
module lc4_superscalar import lc4_isa_pkg::*, lc4_pipe_pkg::*; #(
   parameter word_t reset_pc = 16'h8200
) (
   input  logic     gwe,
   input  logic     i_reset,
   output word_t    o_pc,
   input  word_t    i_insn_a,   // insn at o_pc
   input  word_t    i_insn_b,   // insn at o_pc + 1
   output stall_e   o_stall_a,
   output stall_e   o_stall_b,
   output word_t    o_trace_pc_a,
   output word_t    o_trace_pc_b,
   output word_t    o_trace_insn_a,
   output word_t    o_trace_insn_b,
   output logic     o_regfile_we_a,
   output logic     o_regfile_we_b,
   output reg_idx_t o_regfile_wsel_a,
   output reg_idx_t o_regfile_wsel_b,
   output word_t    o_regfile_data_a,
   output word_t    o_regfile_data_b,
   output logic     o_nzp_we_a,
   output logic     o_nzp_we_b,
   output nzp_t     o_nzp_bits_a,
   output nzp_t     o_nzp_bits_b
);

   reg_idx_t   rs_sel [n_lanes];
   reg_idx_t   rt_sel [n_lanes];
   word_t      rs_data [n_lanes];
   word_t      rt_data [n_lanes];
   reg_write_t retire_wr [n_lanes];
   // trace, indexed by lane
   stall_e     tr_stall [n_lanes];
   word_t      tr_pc [n_lanes];
   word_t      tr_insn [n_lanes];
   logic       tr_we [n_lanes];
   reg_idx_t   tr_wsel [n_lanes];
   word_t      tr_data [n_lanes];
   logic       tr_nzp_we [n_lanes];
   nzp_t       tr_nzp [n_lanes];

   issue_if  issue_bus [n_lanes] ();
   result_if result_bus [n_lanes] ();

   lc4_issue #(.reset_pc(reset_pc)) issue_i (
      .gwe, .i_reset, .i_insn_a, .i_insn_b, .o_pc,
      .o_rs_sel(rs_sel), .o_rt_sel(rt_sel), .i_rs_data(rs_data), .i_rt_data(rt_data),
      .i_retire_wr(retire_wr), .o_issue(issue_bus)
   );

   lc4_regfile regfile_i (
      .gwe, .i_reset, .i_rs_sel(rs_sel), .i_rt_sel(rt_sel),
      .o_rs_data(rs_data), .o_rt_data(rt_data), .i_wr(retire_wr)
   );

   for (genvar g = 0; g < n_lanes; g++) begin : g_lane
      lc4_lane lane_i (.gwe, .i_reset, .i_issue(issue_bus[g]), .o_result(result_bus[g]));
   end

   lc4_retire retire_i (
      .gwe, .i_reset, .i_result(result_bus), .o_wr(retire_wr),
      .o_stall(tr_stall), .o_pc(tr_pc), .o_insn(tr_insn),
      .o_regfile_we(tr_we), .o_regfile_wsel(tr_wsel), .o_regfile_data(tr_data),
      .o_nzp_we(tr_nzp_we), .o_nzp_bits(tr_nzp)
   );

   assign o_stall_a        = tr_stall[0];
   assign o_stall_b        = tr_stall[1];
   assign o_trace_pc_a     = tr_pc[0];
   assign o_trace_pc_b     = tr_pc[1];
   assign o_trace_insn_a   = tr_insn[0];
   assign o_trace_insn_b   = tr_insn[1];
   assign o_regfile_we_a   = tr_we[0];
   assign o_regfile_we_b   = tr_we[1];
   assign o_regfile_wsel_a = tr_wsel[0];
   assign o_regfile_wsel_b = tr_wsel[1];
   assign o_regfile_data_a = tr_data[0];
   assign o_regfile_data_b = tr_data[1];
   assign o_nzp_we_a       = tr_nzp_we[0];
   assign o_nzp_we_b       = tr_nzp_we[1];
   assign o_nzp_bits_a     = tr_nzp[0];
   assign o_nzp_bits_b     = tr_nzp[1];

endmodule

// ==== verilog.f ====
src/lc4_isa_pkg.sv
src/lc4_pipe_pkg.sv
src/lc4_pipe_if.sv
src/lc4_issue.sv
src/lc4_regfile.sv
src/lc4_lane.sv
src/lc4_retire.sv
src/lc4_superscalar.sv
sim/tb_clock_gen.sv
sim/tb_lc4_chk.sv
sim/tb_lc4.sv
